//--- tb.f
design/harness_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/harness_memory.sv
design/harness_controller.sv
design/reset_boot.sv
design/acc_core.sv
design/harness_top.sv
tests/tb_clock.sv
tests/harness_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module harness_tb -o harness_sim
./obj_dir/harness_sim

//--- tests/harness_tb.sv
`timescale 1ns/1ps

module harness_tb;
  import harness_pkg::*;

  localparam int BIT_CLKS      = 8;
  localparam int FRAME_CLKS    = 10 * BIT_CLKS;
  localparam int MEM_WORDS     = 64;
  localparam int RESET_CYCLES  = 16;
  localparam int REPLY_TIMEOUT = 3000;
  localparam int PROG_LEN      = 10;

  // Data locations used by the program
  localparam byte_t HOST_ADDR  = 8'd40;
  localparam byte_t SPARE_ADDR = 8'd41;
  localparam byte_t RES0_ADDR  = 8'd48;
  localparam byte_t RES1_ADDR  = 8'd49;
  localparam byte_t RES2_ADDR  = 8'd50;

  typedef struct packed {
    byte_t      cmd;
    byte_t      addr;
    word_t      data;
    logic [2:0] n_rsp;
    word_t      rsp;
  } txn_t;

  logic  clk;
  logic  arst_n_i;
  logic  rx_i;
  logic  tx_o;
  word_t model_mem [MEM_WORDS];
  word_t lcg_state;
  word_t reply_q;
  txn_t  txn_q [$];

  tb_clock #(.PERIOD_NS(20)) u_clock (
    .clk (clk)
  );

  harness_top #(
    .CLKS_PER_BIT (BIT_CLKS),
    .MEM_WORDS    (MEM_WORDS),
    .RESET_CYCLES (RESET_CYCLES)
  ) UUT (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .rx_i     (rx_i),
    .tx_o     (tx_o)
  );

  task automatic stop_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Host addresses keep only the low bits
  function automatic int slot(input byte_t addr);
    return int'(addr) % MEM_WORDS;
  endfunction

  function automatic word_t imm_word(input opcode_e op, input logic [15:0] imm);
    instr_u ins;
    ins.raw     = '0;
    ins.imm.op  = op;
    ins.imm.imm = imm;
    return ins.raw;
  endfunction

  function automatic word_t mem_word(input opcode_e op, input byte_t addr);
    instr_u ins;
    ins.raw      = '0;
    ins.mem.op   = op;
    ins.mem.addr = addr;
    return ins.raw;
  endfunction

  // ISA reference model running the program in model_mem from pc 0
  task automatic run_model();
    word_t  acc;
    int     pc;
    int     steps;
    logic   halted;
    instr_u ins;
    acc    = '0;
    pc     = 0;
    steps  = 0;
    halted = 1'b0;
    while (!halted) begin
      if (steps >= 4 * MEM_WORDS) begin
        $display("Reference model ran %0d steps without reaching HALT", steps);
        stop_run();
      end else begin
        ins.raw = model_mem[pc];
        steps++;
        case (ins.imm.op)
          LDI:     acc = {16'h0000, ins.imm.imm};
          ADDI:    acc = acc + {16'h0000, ins.imm.imm};
          XORI:    acc = acc ^ {16'h0000, ins.imm.imm};
          LD:      acc = model_mem[slot(ins.mem.addr)];
          ST:      model_mem[slot(ins.mem.addr)] = acc;
          HALT:    halted = 1'b1;
          default: ;
        endcase
        pc = (pc + 1) % MEM_WORDS;
      end
    end
  endtask

  task automatic add_write(input byte_t addr, input word_t data);
    txn_t t;
    t = '{cmd: CMD_WRITE, addr: addr, data: data, n_rsp: 3'd1, rsp: {24'h0, RSP_OK}};
    model_mem[slot(addr)] = data;
    txn_q.push_back(t);
  endtask

  task automatic add_read(input byte_t addr);
    txn_t t;
    t = '{cmd: CMD_READ, addr: addr, data: '0, n_rsp: 3'd4, rsp: model_mem[slot(addr)]};
    txn_q.push_back(t);
  endtask

  task automatic add_go();
    txn_t t;
    run_model();
    t = '{cmd: CMD_GO, addr: '0, data: '0, n_rsp: 3'd1, rsp: {24'h0, RSP_DONE}};
    txn_q.push_back(t);
  endtask

  // A lone byte that should get no answer
  task automatic add_silent(input byte_t cmd);
    txn_t t;
    t = '{cmd: cmd, addr: '0, data: '0, n_rsp: 3'd0, rsp: '0};
    txn_q.push_back(t);
  endtask

  task automatic send_byte(input byte_t b);
    int i;
    @(negedge clk);
    rx_i = 1'b0;
    repeat (BIT_CLKS) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      rx_i = b[i];
      repeat (BIT_CLKS) @(negedge clk);
    end
    rx_i = 1'b1;
    repeat (BIT_CLKS) @(negedge clk);
  endtask

  task automatic send_request(input txn_t t);
    int i;
    send_byte(t.cmd);
    if (t.cmd == CMD_WRITE || t.cmd == CMD_READ) send_byte(t.addr);
    if (t.cmd == CMD_WRITE) begin
      for (i = 0; i < 4; i++) send_byte(t.data[8*i +: 8]);
    end
  endtask

  task automatic receive_byte(output byte_t b);
    int waited;
    int i;
    waited = 0;
    while (tx_o !== 1'b0) begin
      if (waited >= REPLY_TIMEOUT) begin
        $display("Timeout: no start bit on tx_o within %0d clocks", waited);
        stop_run();
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    repeat (BIT_CLKS / 2) @(negedge clk);
    if (tx_o !== 1'b0) begin
      $display("Start bit on tx_o ended before mid-bit at %0t", $time);
      stop_run();
    end
    for (i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      b[i] = tx_o;
    end
    repeat (BIT_CLKS) @(negedge clk);
    if (tx_o !== 1'b1) begin
      $display("Stop bit on tx_o was low at %0t", $time);
      stop_run();
    end
  endtask

  task automatic collect_reply(input int n);
    byte_t b;
    int    i;
    reply_q = '0;
    for (i = 0; i < n; i++) begin
      receive_byte(b);
      reply_q[8*i +: 8] = b;
    end
  endtask

  task automatic expect_idle(input int cycles, input string when);
    int i;
    for (i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (tx_o !== 1'b1) begin
        $display("tx_o left the idle level %s at %0t", when, $time);
        stop_run();
      end
    end
  endtask

  initial begin
    word_t prog [PROG_LEN];
    byte_t rand_addr [20];
    txn_t  cur;
    int    i;

    arst_n_i  = 1'b0;
    rx_i      = 1'b1;
    lcg_state = 32'd23;

    prog[0] = imm_word(LDI, 16'h1234);
    prog[1] = imm_word(ADDI, 16'h0F0F);
    prog[2] = mem_word(ST, RES0_ADDR);
    prog[3] = imm_word(XORI, 16'hFFFF);
    prog[4] = imm_word(opcode_e'(4'h7), 16'hBEEF);
    prog[5] = mem_word(ST, RES1_ADDR);
    prog[6] = mem_word(LD, HOST_ADDR);
    prog[7] = imm_word(ADDI, 16'h0005);
    prog[8] = mem_word(ST, RES2_ADDR);
    prog[9] = imm_word(HALT, 16'h0000);

    // Host write and read back before the program load
    add_write(HOST_ADDR, lcg_next());
    add_read(HOST_ADDR);
    for (i = 0; i < PROG_LEN; i++) add_write(byte_t'(i), prog[i]);

    add_go();
    add_read(RES0_ADDR);
    add_read(RES1_ADDR);
    add_read(RES2_ADDR);
    add_read(HOST_ADDR);

    // Clear one result so the rerun must store it again
    add_write(RES0_ADDR, 32'h0);
    add_read(RES0_ADDR);
    add_write(SPARE_ADDR, lcg_next());
    add_read(SPARE_ADDR);
    add_go();
    add_read(RES0_ADDR);
    add_read(RES1_ADDR);
    add_read(RES2_ADDR);

    add_silent(8'h5A);
    add_read(SPARE_ADDR);

    // Full address byte of which the DUT keeps the low bits
    for (i = 0; i < 20; i++) begin
      rand_addr[i] = byte_t'(lcg_next() >> 24);
      add_write(rand_addr[i], lcg_next());
    end
    for (i = 0; i < 20; i++) add_read(rand_addr[i]);

    repeat (4) @(negedge clk);
    arst_n_i = 1'b1;
    expect_idle(RESET_CYCLES + 8, "after reset");

    foreach (txn_q[k]) begin
      cur = txn_q[k];
      fork
        send_request(cur);
        collect_reply(int'(cur.n_rsp));
      join
      if (cur.n_rsp == 3'd4) begin
        check_word(reply_q, cur.rsp, $sformatf("read of address %0d", cur.addr));
      end else if (cur.n_rsp == 3'd1) begin
        check_byte(reply_q[7:0], cur.rsp[7:0], $sformatf("reply to command %h", cur.cmd));
      end
      expect_idle(2 * FRAME_CLKS, "after the expected reply");
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  // Free running, low for the first half period
  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- design/harness_top.sv
`timescale 1ns/1ps

module harness_top #(
  parameter int CLKS_PER_BIT = 434,
  parameter int MEM_WORDS    = 64,
  parameter int RESET_CYCLES = 16
) (
  input  logic clk,
  input  logic arst_n_i,
  input  logic rx_i,
  output logic tx_o
);
  import harness_pkg::*;

  localparam int AW = $clog2(MEM_WORDS);

  logic          sys_rst_n;
  logic          core_rst_n;
  logic          ifetch_cyc;
  logic [AW-1:0] ifetch_addr;
  logic          ifetch_ack;
  word_t         ifetch_data;
  logic          dmem_cyc;
  logic          dmem_we;
  logic [AW-1:0] dmem_addr;
  word_t         dmem_wdata;
  logic          dmem_ack;
  word_t         dmem_rdata;
  logic          halt;

  reset_boot #(.RESET_CYCLES(RESET_CYCLES)) u_reset_boot (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .rst_n_o  (sys_rst_n)
  );

  harness_controller #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .MEM_WORDS    (MEM_WORDS)
  ) u_controller (
    .clk               (clk),
    .arst_n_i          (sys_rst_n),
    .rx_i              (rx_i),
    .tx_o              (tx_o),
    .ifetch_cyc_i      (ifetch_cyc),
    .ifetch_addr_i     (ifetch_addr),
    .ifetch_ack_o      (ifetch_ack),
    .ifetch_data_o     (ifetch_data),
    .core_dmem_cyc_i   (dmem_cyc),
    .core_dmem_we_i    (dmem_we),
    .core_dmem_addr_i  (dmem_addr),
    .core_dmem_wdata_i (dmem_wdata),
    .core_dmem_ack_o   (dmem_ack),
    .core_dmem_rdata_o (dmem_rdata),
    .halt_i            (halt),
    .core_rst_n_o      (core_rst_n)
  );

  // Core sits in reset until the host sends G
  acc_core #(.MEM_WORDS(MEM_WORDS)) u_core (
    .clk           (clk),
    .arst_n_i      (core_rst_n),
    .ifetch_cyc_o  (ifetch_cyc),
    .ifetch_addr_o (ifetch_addr),
    .ifetch_ack_i  (ifetch_ack),
    .ifetch_data_i (ifetch_data),
    .dmem_cyc_o    (dmem_cyc),
    .dmem_we_o     (dmem_we),
    .dmem_addr_o   (dmem_addr),
    .dmem_wdata_o  (dmem_wdata),
    .dmem_ack_i    (dmem_ack),
    .dmem_rdata_i  (dmem_rdata),
    .halt_o        (halt)
  );

endmodule

//--- design/acc_core.sv
`timescale 1ns/1ps

module acc_core #(
  parameter  int MEM_WORDS = 64,
  localparam int AW        = $clog2(MEM_WORDS)
) (
  input  logic               clk,
  input  logic               arst_n_i,
  output logic               ifetch_cyc_o,
  output logic [AW-1:0]      ifetch_addr_o,
  input  logic               ifetch_ack_i,
  input  harness_pkg::word_t ifetch_data_i,
  output logic               dmem_cyc_o,
  output logic               dmem_we_o,
  output logic [AW-1:0]      dmem_addr_o,
  output harness_pkg::word_t dmem_wdata_o,
  input  logic               dmem_ack_i,
  input  harness_pkg::word_t dmem_rdata_i,
  output logic               halt_o
);
  import harness_pkg::*;

  localparam logic [2:0] S_FETCH = 3'd0;
  localparam logic [2:0] S_IWAIT = 3'd1;
  localparam logic [2:0] S_EXEC  = 3'd2;
  localparam logic [2:0] S_MREQ  = 3'd3;
  localparam logic [2:0] S_MWAIT = 3'd4;
  localparam logic [2:0] S_HALT  = 3'd5;

  logic [2:0]    state_q;
  logic [AW-1:0] pc_q;
  word_t         acc_q;
  instr_u        instr_q;
  opcode_e       op;
  word_t         imm_ext;

  assign op      = instr_q.imm.op;
  assign imm_ext = {16'h0000, instr_q.imm.imm};

  assign ifetch_cyc_o  = (state_q == S_FETCH);
  assign ifetch_addr_o = pc_q;
  assign dmem_cyc_o    = (state_q == S_MREQ);
  assign dmem_we_o     = dmem_cyc_o && (op == ST);
  assign dmem_addr_o   = instr_q.mem.addr[AW-1:0];
  assign dmem_wdata_o  = acc_q;
  assign halt_o        = (state_q == S_EXEC) && (op == HALT);

  always_ff @(posedge clk) begin
    if (state_q == S_IWAIT && ifetch_ack_i) instr_q.raw <= ifetch_data_i;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_FETCH;
      pc_q    <= '0;
      acc_q   <= '0;
    end else begin
      case (state_q)
        S_FETCH: state_q <= S_IWAIT;
        S_IWAIT: if (ifetch_ack_i) state_q <= S_EXEC;
        S_EXEC: begin
          if (op == HALT) begin
            state_q <= S_HALT;
          end else begin
            pc_q <= pc_q + AW'(1);
            case (op)
              LDI:     acc_q <= imm_ext;
              ADDI:    acc_q <= acc_q + imm_ext;
              XORI:    acc_q <= acc_q ^ imm_ext;
              default: ;
            endcase
            // Memory ops take two more cycles
            state_q <= (op == LD || op == ST) ? S_MREQ : S_FETCH;
          end
        end
        S_MREQ: state_q <= S_MWAIT;
        S_MWAIT: if (dmem_ack_i) begin
          if (op == LD) acc_q <= dmem_rdata_i;
          state_q <= S_FETCH;
        end
        // Parked until the controller resets the core
        S_HALT: state_q <= S_HALT;
        default: state_q <= S_FETCH;
      endcase
    end
  end

endmodule

//--- design/reset_boot.sv
`timescale 1ns/1ps

module reset_boot #(
  parameter int RESET_CYCLES = 16
) (
  input  logic clk,
  input  logic arst_n_i,
  output logic rst_n_o
);

  localparam int            CW       = $clog2(RESET_CYCLES + 1);
  localparam logic [CW-1:0] LAST_CNT = CW'(RESET_CYCLES - 1);

  logic [CW-1:0] cnt_q;

  // Goes low at once and comes back on the clock after the count
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q   <= '0;
      rst_n_o <= 1'b0;
    end else if (!rst_n_o) begin
      if (cnt_q == LAST_CNT) rst_n_o <= 1'b1;
      else cnt_q <= cnt_q + CW'(1);
    end
  end

  // System reset stays low for the whole stretch after release
  assert property (@(posedge clk) rst_n_o |-> $past(arst_n_i, RESET_CYCLES))
    else $error("system reset released before the stretch elapsed");

endmodule

//--- design/harness_controller.sv
`timescale 1ns/1ps

module harness_controller #(
  parameter  int CLKS_PER_BIT = 434,
  parameter  int MEM_WORDS    = 64,
  localparam int AW           = $clog2(MEM_WORDS)
) (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               rx_i,
  output logic               tx_o,
  input  logic               ifetch_cyc_i,
  input  logic [AW-1:0]      ifetch_addr_i,
  output logic               ifetch_ack_o,
  output harness_pkg::word_t ifetch_data_o,
  input  logic               core_dmem_cyc_i,
  input  logic               core_dmem_we_i,
  input  logic [AW-1:0]      core_dmem_addr_i,
  input  harness_pkg::word_t core_dmem_wdata_i,
  output logic               core_dmem_ack_o,
  output harness_pkg::word_t core_dmem_rdata_o,
  input  logic               halt_i,
  output logic               core_rst_n_o
);
  import harness_pkg::*;

  localparam logic [2:0] P_IDLE   = 3'd0;
  localparam logic [2:0] P_ADDR   = 3'd1;
  localparam logic [2:0] P_DATA   = 3'd2;
  localparam logic [2:0] P_HWRITE = 3'd3;
  localparam logic [2:0] P_HREAD  = 3'd4;
  localparam logic [2:0] P_RWAIT  = 3'd5;
  localparam logic [2:0] P_SEND   = 3'd6;
  localparam logic [2:0] P_RUN    = 3'd7;

  logic          rx_valid;
  byte_t         rx_byte;
  logic          tx_start;
  logic          tx_busy;
  byte_t         tx_byte;
  logic          mem_cyc;
  logic          mem_we;
  logic [AW-1:0] mem_addr;
  word_t         mem_wdata;
  word_t         mem_rdata;
  logic          mem_ack;
  logic          host_cyc;
  logic          host_we;
  logic          host_ack;
  logic [2:0]    pstate_q;
  logic          is_write_q;
  logic [1:0]    cnt_q;
  logic          run_q;
  logic [AW-1:0] addr_q;
  word_t         data_q;
  word_t         resp_q;

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .rx_i     (rx_i),
    .byte_o   (rx_byte),
    .valid_o  (rx_valid)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (tx_start),
    .byte_i   (tx_byte),
    .tx_o     (tx_o),
    .busy_o   (tx_busy)
  );

  harness_memory #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .ifetch_cyc_i  (ifetch_cyc_i),
    .ifetch_addr_i (ifetch_addr_i),
    .ifetch_ack_o  (ifetch_ack_o),
    .ifetch_data_o (ifetch_data_o),
    .dmem_cyc_i    (mem_cyc),
    .dmem_we_i     (mem_we),
    .dmem_addr_i   (mem_addr),
    .dmem_wdata_i  (mem_wdata),
    .dmem_ack_o    (mem_ack),
    .dmem_rdata_o  (mem_rdata)
  );

  assign host_cyc = (pstate_q == P_HWRITE) || (pstate_q == P_HREAD);
  assign host_we  = (pstate_q == P_HWRITE);
  assign host_ack = mem_ack && !run_q;

  // Core owns the data port only while it runs
  assign mem_cyc           = run_q ? core_dmem_cyc_i   : host_cyc;
  assign mem_we            = run_q ? core_dmem_we_i    : host_we;
  assign mem_addr          = run_q ? core_dmem_addr_i  : addr_q;
  assign mem_wdata         = run_q ? core_dmem_wdata_i : data_q;
  assign core_dmem_ack_o   = mem_ack && run_q;
  assign core_dmem_rdata_o = mem_rdata;

  assign tx_start     = (pstate_q == P_SEND) && !tx_busy;
  assign tx_byte      = resp_q[7:0];
  assign core_rst_n_o = run_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pstate_q   <= P_IDLE;
      is_write_q <= 1'b0;
      cnt_q      <= '0;
      run_q      <= 1'b0;
    end else begin
      case (pstate_q)
        // Unknown command bytes fall through and are dropped
        P_IDLE: if (rx_valid) begin
          if (rx_byte == CMD_WRITE || rx_byte == CMD_READ) begin
            is_write_q <= (rx_byte == CMD_WRITE);
            pstate_q   <= P_ADDR;
          end else if (rx_byte == CMD_GO) begin
            run_q    <= 1'b1;
            pstate_q <= P_RUN;
          end
        end
        P_ADDR: if (rx_valid) begin
          cnt_q    <= '0;
          pstate_q <= is_write_q ? P_DATA : P_HREAD;
        end
        P_DATA: if (rx_valid) begin
          cnt_q <= cnt_q + 2'd1;
          if (cnt_q == 2'd3) pstate_q <= P_HWRITE;
        end
        P_HWRITE: begin
          cnt_q    <= 2'd0;
          pstate_q <= P_SEND;
        end
        P_HREAD: pstate_q <= P_RWAIT;
        P_RWAIT: if (host_ack) begin
          cnt_q    <= 2'd3;
          pstate_q <= P_SEND;
        end
        // cnt_q counts the bytes still to send after this one
        P_SEND: if (tx_start) begin
          if (cnt_q == 2'd0) pstate_q <= P_IDLE;
          else cnt_q <= cnt_q - 2'd1;
        end
        default: if (halt_i) begin
          run_q    <= 1'b0;
          cnt_q    <= 2'd0;
          pstate_q <= P_SEND;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (pstate_q)
      P_ADDR:   if (rx_valid) addr_q <= rx_byte[AW-1:0];
      P_DATA:   if (rx_valid) data_q <= {rx_byte, data_q[31:8]};
      P_HWRITE: resp_q <= {24'h0, RSP_OK};
      P_RWAIT:  if (host_ack) resp_q <= mem_rdata;
      P_SEND:   if (tx_start) resp_q <= {8'h0, resp_q[31:8]};
      P_RUN:    if (halt_i) resp_q <= {24'h0, RSP_DONE};
      default:  ;
    endcase
  end

  // Host accesses and a running core never overlap on the data port
  assert property (@(posedge clk) disable iff (!arst_n_i) host_cyc |-> !run_q)
    else $error("host data access while the core is running");

endmodule

//--- design/harness_memory.sv
`timescale 1ns/1ps

module harness_memory #(
  parameter  int MEM_WORDS = 64,
  localparam int AW        = $clog2(MEM_WORDS)
) (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               ifetch_cyc_i,
  input  logic [AW-1:0]      ifetch_addr_i,
  output logic               ifetch_ack_o,
  output harness_pkg::word_t ifetch_data_o,
  input  logic               dmem_cyc_i,
  input  logic               dmem_we_i,
  input  logic [AW-1:0]      dmem_addr_i,
  input  harness_pkg::word_t dmem_wdata_i,
  output logic               dmem_ack_o,
  output harness_pkg::word_t dmem_rdata_o
);
  import harness_pkg::*;

  word_t mem_q [MEM_WORDS];

  // Both ports registered, read data is the old word on a write
  always_ff @(posedge clk) begin
    if (ifetch_cyc_i) ifetch_data_o <= mem_q[ifetch_addr_i];
    if (dmem_cyc_i) begin
      if (dmem_we_i) mem_q[dmem_addr_i] <= dmem_wdata_i;
      dmem_rdata_o <= mem_q[dmem_addr_i];
    end
  end

  // Fixed one-cycle ack on each port
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ifetch_ack_o <= 1'b0;
      dmem_ack_o   <= 1'b0;
    end else begin
      ifetch_ack_o <= ifetch_cyc_i;
      dmem_ack_o   <= dmem_cyc_i;
    end
  end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               start_i,
  input  harness_pkg::byte_t byte_i,
  output logic               tx_o,
  output logic               busy_o
);

  localparam int            TW       = $clog2(CLKS_PER_BIT + 1);
  localparam logic [TW-1:0] LAST_CLK = TW'(CLKS_PER_BIT - 1);

  logic [9:0]    shift_q;
  logic [TW-1:0] timer_q;
  logic [3:0]    bit_q;

  // Line follows the low end of the frame, all ones when idle
  assign tx_o = shift_q[0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      shift_q <= '1;
      timer_q <= '0;
      bit_q   <= '0;
      busy_o  <= 1'b0;
    end else if (!busy_o) begin
      if (start_i) begin
        shift_q <= {1'b1, byte_i, 1'b0};
        timer_q <= '0;
        bit_q   <= '0;
        busy_o  <= 1'b1;
      end
    end else if (timer_q == LAST_CLK) begin
      timer_q <= '0;
      shift_q <= {1'b1, shift_q[9:1]};
      bit_q   <= bit_q + 4'd1;
      if (bit_q == 4'd9) busy_o <= 1'b0;
    end else begin
      timer_q <= timer_q + TW'(1);
    end
  end

  // Caller must wait out the current frame
  assert property (@(posedge clk) disable iff (!arst_n_i) start_i |-> !busy_o)
    else $error("uart_tx started while a frame is in flight");

endmodule

//--- design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               rx_i,
  output harness_pkg::byte_t byte_o,
  output logic               valid_o
);
  import harness_pkg::*;

  localparam int            TW       = $clog2(CLKS_PER_BIT + 1);
  localparam logic [TW-1:0] MID_BIT  = TW'(CLKS_PER_BIT / 2 - 1);
  localparam logic [TW-1:0] LAST_CLK = TW'(CLKS_PER_BIT - 1);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  logic          rx_meta;
  logic          rx_sync;
  logic [1:0]    state_q;
  logic [TW-1:0] timer_q;
  logic [2:0]    bit_q;
  byte_t         shift_q;
  logic          sample_bit;
  logic          frame_ok;

  assign sample_bit = (state_q == S_DATA) && (timer_q == LAST_CLK);
  assign frame_ok   = (state_q == S_STOP) && (timer_q == LAST_CLK) && rx_sync;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      state_q <= S_IDLE;
      timer_q <= '0;
      bit_q   <= '0;
      valid_o <= 1'b0;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      valid_o <= frame_ok;
      timer_q <= timer_q + TW'(1);
      case (state_q)
        S_IDLE: begin
          timer_q <= '0;
          if (!rx_sync) state_q <= S_START;
        end
        // Start bit must still be low at its middle
        S_START: if (timer_q == MID_BIT) begin
          timer_q <= '0;
          bit_q   <= '0;
          state_q <= rx_sync ? S_IDLE : S_DATA;
        end
        S_DATA: if (sample_bit) begin
          timer_q <= '0;
          bit_q   <= bit_q + 3'd1;
          if (bit_q == 3'd7) state_q <= S_STOP;
        end
        // Frame with a low stop bit is discarded
        default: if (timer_q == LAST_CLK) state_q <= S_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (sample_bit) shift_q <= {rx_sync, shift_q[7:1]};
    if (frame_ok) byte_o <= shift_q;
  end

endmodule

//--- design/harness_pkg.sv
package harness_pkg;

  typedef logic [31:0] word_t;
  typedef logic [7:0]  byte_t;

  // Core operations, unlisted codes execute as no-ops
  typedef enum logic [3:0] {
    LDI  = 4'h1,
    ADDI = 4'h2,
    XORI = 4'h3,
    LD   = 4'h4,
    ST   = 4'h5,
    HALT = 4'hF
  } opcode_e;

  // Immediate view, zero-extended 16-bit operand
  typedef struct packed {
    opcode_e     op;
    logic [11:0] unused;
    logic [15:0] imm;
  } instr_imm_t;

  // Memory view, word address in the low byte
  typedef struct packed {
    opcode_e     op;
    logic [19:0] unused;
    logic [7:0]  addr;
  } instr_mem_t;

  typedef union packed {
    word_t      raw;
    instr_imm_t imm;
    instr_mem_t mem;
  } instr_u;

  // Host protocol bytes, ASCII
  localparam byte_t CMD_WRITE = 8'h57;
  localparam byte_t CMD_READ  = 8'h52;
  localparam byte_t CMD_GO    = 8'h47;
  localparam byte_t RSP_OK    = 8'h4B;
  localparam byte_t RSP_DONE  = 8'h44;

endpackage
